// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    // key vector layout, player 2 in the low nibble
    localparam int KEY_W        = 10;
    localparam int KEY_P2_UP    = 0;
    localparam int KEY_P2_LEFT  = 1;
    localparam int KEY_P2_DOWN  = 2;
    localparam int KEY_P2_RIGHT = 3;
    localparam int KEY_P1_UP    = 4;
    localparam int KEY_P1_LEFT  = 5;
    localparam int KEY_P1_DOWN  = 6;
    localparam int KEY_P1_RIGHT = 7;
    localparam int KEY_START    = 8;
    localparam int KEY_ESCAPE   = 9;

    typedef logic [2:0] level_t;

    localparam level_t LEVEL_MIN = 3'd1;
    localparam level_t LEVEL_MAX = 3'd5;

    typedef enum logic [3:0] {
        POSE_STILL = 4'd6,
        POSE_RIGHT = 4'd7,
        POSE_LEFT  = 4'd8,
        POSE_UP    = 4'd9
    } pose_t;

    typedef enum logic [1:0] {
        JUMP_GROUND = 2'd0,
        JUMP_RISE   = 2'd1,
        JUMP_FALL   = 2'd2
    } jump_phase_t;

    // jump timing, shortened for simulation
    localparam int JUMP_CNT_W = 8;
    typedef logic [JUMP_CNT_W-1:0] jump_cnt_t;

    localparam jump_cnt_t JUMP_RISE_LIMIT = 8'd12;
    localparam jump_cnt_t JUMP_FALL_LIMIT = 8'd40;

    // menu geometry in half-resolution pixels
    localparam int VGA_W        = 10;
    localparam int PIX_ADDR_W   = 17;
    localparam int FB_WIDTH     = 320;
    localparam int ROW_TOP      = 40;
    localparam int ROW_PITCH    = 40;
    localparam int ROW_HEIGHT   = 25;
    localparam int ICON_H_START = 150;
    localparam int ICON_H_END   = 170;
    localparam int SEL_H_START  = 148;
    localparam int SEL_H_BASE   = 127;

endpackage

`default_nettype wire

// ==== level_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module level_select (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [game_pkg::KEY_W-1:0] key_down,
    input  logic                      been_ready,
    output game_pkg::level_t          level,
    output logic                      playing,
    output logic                      show_cover
);
    import game_pkg::*;

    // one action per press, re-armed once every key is up
    logic armed;

    logic key_inc;
    logic key_dec;
    logic key_start;
    logic key_leave;

    assign key_inc   = key_down[KEY_P2_UP] || key_down[KEY_P1_UP];
    assign key_dec   = key_down[KEY_P2_DOWN] || key_down[KEY_P1_DOWN];
    assign key_start = key_down[KEY_START];
    assign key_leave = key_down[KEY_START] || key_down[KEY_ESCAPE];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level      <= LEVEL_MIN;
            playing    <= 1'b0;
            show_cover <= 1'b1;
            armed      <= 1'b1;
        end else if (!playing) begin
            if (key_down == '0) begin
                armed <= 1'b1;
            end else if (armed) begin
                if (key_inc) begin
                    if (level < LEVEL_MAX) begin
                        level <= level + 3'd1;
                    end
                    armed <= 1'b0;
                end else if (key_dec) begin
                    if (level > LEVEL_MIN) begin
                        level <= level - 3'd1;
                    end
                    armed <= 1'b0;
                end else if (key_start) begin
                    // first start only drops the title screen
                    if (show_cover) begin
                        show_cover <= 1'b0;
                    end else begin
                        playing <= 1'b1;
                    end
                    armed <= 1'b0;
                end
            end
        end else begin
            if (key_leave && been_ready) begin
                playing <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== player_motion.sv ====
`timescale 1ns/100ps
`default_nettype none

module player_motion (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  playing,
    input  logic                  key_up,
    input  logic                  key_left,
    input  logic                  key_down_dir,
    input  logic                  key_right,
    input  logic                  collision,
    input  logic                  land,
    input  logic                  should_down,
    output game_pkg::pose_t       pose,
    output game_pkg::jump_phase_t phase
);
    import game_pkg::*;

    jump_cnt_t   cnt;

    pose_t       pose_n;
    jump_phase_t phase_n;
    jump_cnt_t   cnt_n;

    // results of a fall step and of a full jump step
    jump_phase_t fall_phase;
    jump_cnt_t   fall_cnt;
    jump_phase_t jump_phase;
    jump_cnt_t   jump_cnt;

    logic no_dir;
    logic up_only;
    logic go_left;
    logic go_right;
    logic airborne;

    assign no_dir   = !key_up && !key_left && !key_down_dir && !key_right;
    assign up_only  = key_up && !key_left && !key_down_dir && !key_right;
    assign go_left  = (key_left || key_up) && !key_right;
    assign go_right = (key_right || key_up) && !key_left;
    assign airborne = (phase != JUMP_GROUND);

    always_comb begin
        if (cnt < JUMP_FALL_LIMIT && !land) begin
            fall_phase = JUMP_FALL;
            fall_cnt   = cnt + 1'b1;
        end else begin
            fall_phase = JUMP_GROUND;
            fall_cnt   = '0;
        end
    end

    always_comb begin
        // keep rising until the limit or a hit from above
        if (phase != JUMP_FALL && cnt < JUMP_RISE_LIMIT && !collision) begin
            jump_phase = JUMP_RISE;
            jump_cnt   = cnt + 1'b1;
        end else begin
            jump_phase = fall_phase;
            jump_cnt   = fall_cnt;
        end
    end

    always_comb begin
        pose_n  = pose;
        phase_n = phase;
        cnt_n   = cnt;
        if (!playing) begin
            pose_n  = POSE_STILL;
            phase_n = JUMP_GROUND;
            cnt_n   = '0;
        end else if (no_dir) begin
            if (!airborne) begin
                pose_n  = POSE_STILL;
                phase_n = JUMP_GROUND;
                cnt_n   = '0;
            end else begin
                phase_n = jump_phase;
                cnt_n   = jump_cnt;
            end
        end else if (up_only) begin
            pose_n  = POSE_UP;
            phase_n = jump_phase;
            cnt_n   = jump_cnt;
        end else if (go_left || go_right) begin
            pose_n = go_left ? POSE_LEFT : POSE_RIGHT;
            if ((key_up || airborne) && !should_down) begin
                phase_n = jump_phase;
                cnt_n   = jump_cnt;
            end else if (should_down) begin
                phase_n = fall_phase;
                cnt_n   = fall_cnt;
            end else begin
                // walking on ground, counter left as is
                phase_n = JUMP_GROUND;
            end
        end else if (airborne) begin
            phase_n = jump_phase;
            cnt_n   = jump_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pose  <= POSE_STILL;
            phase <= JUMP_GROUND;
            cnt   <= '0;
        end else begin
            pose  <= pose_n;
            phase <= phase_n;
            cnt   <= cnt_n;
        end
    end

endmodule

`default_nettype wire

// ==== menu_pixel_addr.sv ====
`timescale 1ns/100ps
`default_nettype none

module menu_pixel_addr (
    input  logic                            clk,
    input  logic                            rst,
    input  game_pkg::level_t                level,
    input  logic                            playing,
    input  logic                            show_cover,
    input  logic [game_pkg::VGA_W-1:0]      vga_h,
    input  logic [game_pkg::VGA_W-1:0]      vga_v,
    output logic [game_pkg::PIX_ADDR_W-1:0] pixel_addr
);
    import game_pkg::*;

    logic [VGA_W-1:0]      h_half;
    logic [VGA_W-1:0]      v_half;
    logic [PIX_ADDR_W-1:0] addr_next;

    // framebuffer is 320x240, half of the VGA raster
    assign h_half = vga_h >> 1;
    assign v_half = vga_v >> 1;

    function automatic int row_top_of(input int k);
        return ROW_TOP + ROW_PITCH * k;
    endfunction

    always_comb begin
        addr_next = '0;
        for (int k = 0; k < int'(LEVEL_MAX); k++) begin
            if (v_half >= row_top_of(k) && v_half < row_top_of(k) + ROW_HEIGHT) begin
                if (level == level_t'(k + 1)) begin
                    // selected row also shows the marker left of the icon
                    if (h_half >= SEL_H_START && h_half < ICON_H_END) begin
                        addr_next = PIX_ADDR_W'(h_half - SEL_H_BASE)
                            + PIX_ADDR_W'((v_half - (row_top_of(k) - 1)) * FB_WIDTH);
                    end
                end else if (h_half >= ICON_H_START && h_half < ICON_H_END) begin
                    addr_next = PIX_ADDR_W'(h_half - ICON_H_START)
                        + PIX_ADDR_W'((v_half - (row_top_of(k) - 1)) * FB_WIDTH);
                end
            end
        end
        if (playing || show_cover) begin
            addr_next = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_addr <= '0;
        end else begin
            pixel_addr <= addr_next;
        end
    end

endmodule

`default_nettype wire

// ==== game_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [game_pkg::KEY_W-1:0]      key_down,
    input  logic                            been_ready,
    input  logic [game_pkg::VGA_W-1:0]      vga_h,
    input  logic [game_pkg::VGA_W-1:0]      vga_v,
    input  logic                            p1_collision,
    input  logic                            p1_land,
    input  logic                            p1_should_down,
    input  logic                            p2_collision,
    input  logic                            p2_land,
    input  logic                            p2_should_down,
    output game_pkg::level_t                level,
    output logic                            playing,
    output logic                            show_cover,
    output game_pkg::pose_t                 p1_pose,
    output game_pkg::jump_phase_t           p1_phase,
    output game_pkg::pose_t                 p2_pose,
    output game_pkg::jump_phase_t           p2_phase,
    output logic [game_pkg::PIX_ADDR_W-1:0] pixel_addr
);
    import game_pkg::*;

    level_select level_select_i (
        .clk        (clk),
        .rst        (rst),
        .key_down   (key_down),
        .been_ready (been_ready),
        .level      (level),
        .playing    (playing),
        .show_cover (show_cover)
    );

    // player 1 on the upper key nibble
    player_motion p1_motion_i (
        .clk          (clk),
        .rst          (rst),
        .playing      (playing),
        .key_up       (key_down[KEY_P1_UP]),
        .key_left     (key_down[KEY_P1_LEFT]),
        .key_down_dir (key_down[KEY_P1_DOWN]),
        .key_right    (key_down[KEY_P1_RIGHT]),
        .collision    (p1_collision),
        .land         (p1_land),
        .should_down  (p1_should_down),
        .pose         (p1_pose),
        .phase        (p1_phase)
    );

    player_motion p2_motion_i (
        .clk          (clk),
        .rst          (rst),
        .playing      (playing),
        .key_up       (key_down[KEY_P2_UP]),
        .key_left     (key_down[KEY_P2_LEFT]),
        .key_down_dir (key_down[KEY_P2_DOWN]),
        .key_right    (key_down[KEY_P2_RIGHT]),
        .collision    (p2_collision),
        .land         (p2_land),
        .should_down  (p2_should_down),
        .pose         (p2_pose),
        .phase        (p2_phase)
    );

    menu_pixel_addr menu_pixel_addr_i (
        .clk        (clk),
        .rst        (rst),
        .level      (level),
        .playing    (playing),
        .show_cover (show_cover),
        .vga_h      (vga_h),
        .vga_v      (vga_v),
        .pixel_addr (pixel_addr)
    );

endmodule

`default_nettype wire

// ==== game_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_checker (
    input logic                  clk,
    input logic                  rst,
    input game_pkg::level_t      level,
    input logic                  playing,
    input logic                  show_cover,
    input game_pkg::pose_t       p1_pose,
    input game_pkg::jump_phase_t p1_phase,
    input game_pkg::pose_t       p2_pose,
    input game_pkg::jump_phase_t p2_phase
);
    import game_pkg::*;

    level_in_range: assert property (@(posedge clk) disable iff (rst)
        level >= LEVEL_MIN && level <= LEVEL_MAX)
        else $error("level %0d outside the menu range", level);

    // encoding 3 has no meaning for the jump phase
    phase_valid: assert property (@(posedge clk) disable iff (rst)
        p1_phase != 2'd3 && p2_phase != 2'd3)
        else $error("jump phase holds the unused encoding");

    p1_pose_valid: assert property (@(posedge clk) disable iff (rst)
        p1_pose inside {POSE_STILL, POSE_RIGHT, POSE_LEFT, POSE_UP})
        else $error("player 1 pose %0d is not a valid pose", p1_pose);

    p2_pose_valid: assert property (@(posedge clk) disable iff (rst)
        p2_pose inside {POSE_STILL, POSE_RIGHT, POSE_LEFT, POSE_UP})
        else $error("player 2 pose %0d is not a valid pose", p2_pose);

    play_without_cover: assert property (@(posedge clk) disable iff (rst)
        playing |-> !show_cover)
        else $error("play started while the cover is still shown");

endmodule

`default_nettype wire

// ==== tb_game_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_game_top;
    import game_pkg::*;

    // about 3000 cycles of tests, generous margin
    localparam int CYCLE_LIMIT = 20000;

    logic                  clk;
    logic                  rst;
    logic [KEY_W-1:0]      key_down;
    logic                  been_ready;
    logic [VGA_W-1:0]      vga_h;
    logic [VGA_W-1:0]      vga_v;
    // per player: should_down, land, collision
    logic [2:0]            p1_flags;
    logic [2:0]            p2_flags;
    logic [2:0]            level;
    logic                  playing;
    logic                  show_cover;
    logic [3:0]            p1_pose;
    logic [1:0]            p1_phase;
    logic [3:0]            p2_pose;
    logic [1:0]            p2_phase;
    logic [PIX_ADDR_W-1:0] pixel_addr;

    // reference model, index 0 is player 1
    int m_level;
    int m_playing;
    int m_cover;
    int m_armed;
    int m_addr;
    int m_pose[2];
    int m_phase[2];
    int m_cnt[2];
    int cycles = 0;
    int errors = 0;
    int test_errors = 0;
    int tests = 0;
    int rise_len;
    int fall_len;

    game_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .key_down       (key_down),
        .been_ready     (been_ready),
        .vga_h          (vga_h),
        .vga_v          (vga_v),
        .p1_collision   (p1_flags[0]),
        .p1_land        (p1_flags[1]),
        .p1_should_down (p1_flags[2]),
        .p2_collision   (p2_flags[0]),
        .p2_land        (p2_flags[1]),
        .p2_should_down (p2_flags[2]),
        .level          (level),
        .playing        (playing),
        .show_cover     (show_cover),
        .p1_pose        (p1_pose),
        .p1_phase       (p1_phase),
        .p2_pose        (p2_pose),
        .p2_phase       (p2_phase),
        .pixel_addr     (pixel_addr)
    );

    bind game_top game_checker checker_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic int expected_addr(input int lvl, input int h_raw, input int v_raw);
        int h;
        int v;
        int top;
        h = h_raw / 2;
        v = v_raw / 2;
        for (int k = 0; k < 5; k++) begin
            top = ROW_TOP + ROW_PITCH * k;
            if (v >= top && v < top + ROW_HEIGHT) begin
                if (k == lvl - 1 && h >= SEL_H_START && h < ICON_H_END)
                    return (h - SEL_H_BASE) + (v - top + 1) * FB_WIDTH;
                if (k != lvl - 1 && h >= ICON_H_START && h < ICON_H_END)
                    return (h - ICON_H_START) + (v - top + 1) * FB_WIDTH;
            end
        end
        return 0;
    endfunction

    // full jump step, or only its falling half
    task automatic jump_step(input int i, input bit [2:0] fl, input bit full);
        if (full && m_phase[i] != JUMP_FALL && m_cnt[i] < 12 && !fl[0]) begin
            m_phase[i] = JUMP_RISE;
            m_cnt[i]++;
        end else if (m_cnt[i] < 40 && !fl[1]) begin
            m_phase[i] = JUMP_FALL;
            m_cnt[i]++;
        end else begin
            m_phase[i] = JUMP_GROUND;
            m_cnt[i] = 0;
        end
    endtask

    // dir holds up, left, down, right from bit 0
    task automatic motion_step(input int i, input bit [3:0] dir, input bit [2:0] fl);
        bit up;
        bit left;
        bit right;
        bit air;
        up = dir[0];
        left = dir[1];
        right = dir[3];
        air = (m_phase[i] != JUMP_GROUND);
        if (!m_playing) begin
            m_pose[i] = POSE_STILL;
            m_phase[i] = JUMP_GROUND;
            m_cnt[i] = 0;
        end else if (dir == 4'b0000) begin
            if (air) begin
                jump_step(i, fl, 1'b1);
            end else begin
                m_pose[i] = POSE_STILL;
                m_cnt[i] = 0;
            end
        end else if (dir == 4'b0001) begin
            m_pose[i] = POSE_UP;
            jump_step(i, fl, 1'b1);
        end else if (((left || up) && !right) || ((right || up) && !left)) begin
            m_pose[i] = ((left || up) && !right) ? POSE_LEFT : POSE_RIGHT;
            if ((up || air) && !fl[2])
                jump_step(i, fl, 1'b1);
            else if (fl[2])
                jump_step(i, fl, 1'b0);
            else
                m_phase[i] = JUMP_GROUND;
        end else if (air) begin
            jump_step(i, fl, 1'b1);
        end
    endtask

    task automatic menu_step();
        if (m_playing) begin
            if ((key_down[KEY_START] || key_down[KEY_ESCAPE]) && been_ready)
                m_playing = 0;
        end else if (key_down == '0) begin
            m_armed = 1;
        end else if (m_armed) begin
            if (key_down[KEY_P2_UP] || key_down[KEY_P1_UP]) begin
                if (m_level < 5)
                    m_level++;
                m_armed = 0;
            end else if (key_down[KEY_P2_DOWN] || key_down[KEY_P1_DOWN]) begin
                if (m_level > 1)
                    m_level--;
                m_armed = 0;
            end else if (key_down[KEY_START]) begin
                if (m_cover)
                    m_cover = 0;
                else
                    m_playing = 1;
                m_armed = 0;
            end
        end
    endtask

    // model advances on the same edge as the DUT, from the old inputs
    always @(posedge clk) begin
        if (rst) begin
            m_level = 1;
            m_playing = 0;
            m_cover = 1;
            m_armed = 1;
            m_addr = 0;
            for (int i = 0; i < 2; i++) begin
                m_pose[i] = POSE_STILL;
                m_phase[i] = JUMP_GROUND;
                m_cnt[i] = 0;
            end
        end else begin
            m_addr = (m_playing || m_cover) ? 0 : expected_addr(m_level, vga_h, vga_v);
            motion_step(0, key_down[7:4], p1_flags);
            motion_step(1, key_down[3:0], p2_flags);
            menu_step();
        end
    end

    task automatic compare_output(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h, cycle %0d", name, got, exp, cycles);
            errors++;
            test_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            compare_output("level", level, m_level);
            compare_output("playing", playing, m_playing);
            compare_output("show_cover", show_cover, m_cover);
            compare_output("p1_pose", p1_pose, m_pose[0]);
            compare_output("p1_phase", p1_phase, m_phase[0]);
            compare_output("p2_pose", p2_pose, m_pose[1]);
            compare_output("p2_phase", p2_phase, m_phase[1]);
            compare_output("pixel_addr", pixel_addr, m_addr);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic end_test(input string name);
        tests++;
        $display("test %-20s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic drive_keys(input logic [KEY_W-1:0] keys, input int n);
        @(posedge clk);
        key_down <= keys;
        repeat (n - 1) @(posedge clk);
    endtask

    task automatic tap_key(input logic [KEY_W-1:0] keys);
        drive_keys(keys, 2);
        drive_keys('0, 2);
    endtask

    initial begin
        void'($urandom(42));
        rst = 1'b1;
        key_down = '0;
        been_ready = 1'b0;
        vga_h = '0;
        vga_v = '0;
        p1_flags = '0;
        p2_flags = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_output("level", level, 1);
        compare_output("playing", playing, 0);
        compare_output("show_cover", show_cover, 1);
        compare_output("p1_pose", p1_pose, POSE_STILL);
        compare_output("p2_pose", p2_pose, POSE_STILL);
        compare_output("p1_phase", p1_phase, JUMP_GROUND);
        compare_output("p2_phase", p2_phase, JUMP_GROUND);
        compare_output("pixel_addr", pixel_addr, 0);
        end_test("reset values");

        // walk into both clamps, then random presses without start
        repeat (7) tap_key(10'h010);
        repeat (7) tap_key(10'h004);
        repeat (400) begin
            @(posedge clk);
            key_down <= ($urandom_range(2) == 0) ? '0 : KEY_W'($urandom) & 10'h2ff;
            vga_h <= VGA_W'($urandom_range(639));
            vga_v <= VGA_W'($urandom_range(479));
        end
        drive_keys('0, 2);
        end_test("menu navigation");

        tap_key(10'h100);
        tap_key(10'h100);
        // p1 jumps straight up, p2 jumps to the right
        drive_keys(10'h019, 6);
        drive_keys(10'h208, 3);
        @(negedge clk);
        compare_output("playing", playing, 1);
        @(posedge clk);
        key_down <= 10'h208;
        been_ready <= 1'b1;
        @(posedge clk);
        key_down <= '0;
        been_ready <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_output("playing", playing, 0);
        compare_output("p1_pose", p1_pose, POSE_STILL);
        compare_output("p2_pose", p2_pose, POSE_STILL);
        compare_output("p1_phase", p1_phase, JUMP_GROUND);
        compare_output("p2_phase", p2_phase, JUMP_GROUND);
        end_test("cover and play entry");

        tap_key(10'h100);
        rise_len = 0;
        fall_len = 0;
        drive_keys(10'h011, 1);
        for (int n = 0; n < 100; n++) begin
            @(negedge clk);
            if (p1_phase == JUMP_RISE)
                rise_len++;
            else if (p1_phase == JUMP_FALL)
                fall_len++;
            else if (rise_len + fall_len > 0)
                break;
        end
        compare_output("rise cycles", rise_len, 12);
        compare_output("fall cycles", fall_len, 28);
        repeat (300) begin
            @(posedge clk);
            p1_flags <= {1'b0, $urandom_range(7) == 0, $urandom_range(7) == 0};
            p2_flags <= {1'b0, $urandom_range(5) == 0, $urandom_range(9) == 0};
        end
        end_test("jump timing");

        repeat (1000) begin
            @(posedge clk);
            key_down <= KEY_W'($urandom);
            p1_flags <= 3'($urandom) & 3'($urandom);
            p2_flags <= 3'($urandom) & 3'($urandom);
        end
        end_test("random motion");

        // start with the ready strobe also leaves play
        @(posedge clk);
        key_down <= 10'h100;
        been_ready <= 1'b1;
        p1_flags <= '0;
        p2_flags <= '0;
        @(posedge clk);
        key_down <= '0;
        been_ready <= 1'b0;
        repeat (5) tap_key(10'h004);
        for (int lv = 0; lv < 6; lv++) begin
            // last round runs in play, where the address stays 0
            if (lv == 5)
                tap_key(10'h100);
            repeat (120) begin
                @(posedge clk);
                vga_h <= VGA_W'(260 + $urandom_range(100));
                vga_v <= VGA_W'($urandom_range(479));
            end
            if (lv < 4)
                tap_key(10'h010);
        end
        end_test("menu addresses");

        $display("tests %0d, cycles %0d, errors %0d", tests, cycles, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
game_pkg.sv
level_select.sv
player_motion.sv
menu_pixel_addr.sv
game_top.sv
game_checker.sv
tb_game_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_game_top \
    -f build.f -o tb_game_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_game_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1
